// File: Makefile
# Verilator build and run for the avionics control core

SRCS := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vavionics_tb: $(SRCS) sources.f
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module avionics_tb -o Vavionics_tb

run: obj_dir/Vavionics_tb
	./obj_dir/Vavionics_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Testbench passed" sim.log || \
		(echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: sources.f
+incdir+verilog
verilog/avionics_pkg.sv
verilog/button_debounce.sv
verilog/tick_gen.sv
verilog/host_regs.sv
verilog/board_sequencer.sv
verilog/indicator.sv
verilog/avionics_top.sv
verif/avionics_tb.sv

// File: verif/avionics_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avionics control core testbench
// Random host commands, button presses, LED and
// timestamp checks against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "avionics_params.svh"

module avionics_tb;

  localparam int         CLK_PERIOD  = 8;
  // Clocks allowed for any single wait
  localparam int         WAIT_LIMIT  = 400;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                  clk;
  logic                  arst_n;
  logic                  btn;
  logic [7:0]            led;
  logic                  awvalid;
  logic                  awready;
  logic [`AV_ADDR_W-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [`AV_DATA_W-1:0] wdata;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [`AV_ADDR_W-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [`AV_DATA_W-1:0] rdata;
  logic [1:0]            rresp;

  // LCG state and reference model
  logic [31:0]               lcg_state;
  avionics_pkg::board_mode_e exp_mode;
  logic                      exp_fault;
  logic [`AV_TS_W-1:0]       exp_time;

  // Port names match the top level one to one
  avionics_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Upper state bits, the low ones have short periods
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, lcg_state[31:8]};
  endfunction

  // Idle, startup, running, shutdown, then wrap
  function automatic avionics_pkg::board_mode_e next_mode(input avionics_pkg::board_mode_e m);
    return avionics_pkg::board_mode_e'(m + 2'd1);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  // One clock of a bounded wait, sampled on the falling edge
  task automatic tick_wait(inout int waited, input string what);
    @(negedge clk);
    waited++;
    if (waited > WAIT_LIMIT) begin
      abort_run({"Timeout waiting for ", what});
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int waited;
    int stall;
    stall = int'(next_rand() % 4);
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    waited = 0;
    do begin
      tick_wait(waited, "awready");
    end while (!awready);
    // Address and data are taken in the same cycle
    check("wready", 32'(wready), 32'd1);
    // Accept edge
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // Back-pressure on the response
    repeat (stall) @(posedge clk);
    bready <= 1'b1;
    waited = 0;
    do begin
      tick_wait(waited, "bvalid");
    end while (!bvalid);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    int stall;
    stall = int'(next_rand() % 4);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    waited = 0;
    do begin
      tick_wait(waited, "arready");
    end while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    repeat (stall) @(posedge clk);
    rready <= 1'b1;
    waited = 0;
    do begin
      tick_wait(waited, "rvalid");
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Reserved bits get random fill, the DUT must ignore them
  task automatic send_cmd(input avionics_pkg::cmd_op_e op, input logic [31:0] arg);
    logic [31:0] rnd;
    logic [31:0] word;
    logic [1:0]  resp;
    logic [1:0]  exp_resp;
    rnd      = next_rand();
    word     = {op, rnd[29:0]};
    exp_resp = RESP_OKAY;
    case (op)
      avionics_pkg::ADVANCE: exp_mode = next_mode(exp_mode);
      avionics_pkg::GOTO: begin
        word[1:0] = arg[1:0];
        exp_mode  = avionics_pkg::board_mode_e'(arg[1:0]);
      end
      avionics_pkg::TIME_LOAD: begin
        word[23:0] = arg[23:0];
        exp_time   = arg[23:0];
      end
      default: begin
        exp_fault = 1'b1;
        exp_resp  = RESP_SLVERR;
      end
    endcase
    // Any move into idle clears the fault
    if ((op == avionics_pkg::ADVANCE || op == avionics_pkg::GOTO) &&
        exp_mode == avionics_pkg::IDLE) begin
      exp_fault = 1'b0;
    end
    axil_write(`AV_REG_CMD, word, resp);
    check("bresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic goto_mode(input avionics_pkg::board_mode_e m);
    send_cmd(avionics_pkg::GOTO, {30'h0, m});
  endtask

  task automatic check_status();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(`AV_REG_STATUS, data, resp);
    check("rresp", 32'(resp), 32'(RESP_OKAY));
    check("status", data,
          {24'h0, exp_mode == avionics_pkg::RUNNING, exp_fault, 4'h0, exp_mode});
  endtask

  task automatic press_button();
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    @(posedge clk);
    btn <= 1'b1;
    exp_mode = next_mode(exp_mode);
    if (exp_mode == avionics_pkg::IDLE) begin
      exp_fault = 1'b0;
    end
    polls = 0;
    do begin
      axil_read(`AV_REG_STATUS, data, resp);
      polls++;
      if (polls > 50) begin
        abort_run("Timeout waiting for a button press to step the mode");
      end
    end while (data[1:0] != exp_mode);
    @(posedge clk);
    btn <= 1'b0;
    // Release has to settle without a second step
    repeat (`AV_DEBOUNCE_CYCLES + 8) @(posedge clk);
    check_status();
  endtask

  // High for half the debounce window only
  task automatic glitch_button();
    @(posedge clk);
    btn <= 1'b1;
    repeat (`AV_DEBOUNCE_CYCLES / 2) @(posedge clk);
    btn <= 1'b0;
    repeat (`AV_DEBOUNCE_CYCLES + 8) @(posedge clk);
    check_status();
  endtask

  task automatic check_leds(input avionics_pkg::board_mode_e m, input int window,
                            input logic exp_on, input logic exp_off);
    logic seen_on;
    logic seen_off;
    goto_mode(m);
    repeat (3) @(posedge clk);
    seen_on  = 1'b0;
    seen_off = 1'b0;
    repeat (window) begin
      @(negedge clk);
      check("led_is_solid", 32'(led == 8'h00 || led == 8'hff), 32'd1);
      seen_on  = seen_on | (led == 8'hff);
      seen_off = seen_off | (led == 8'h00);
    end
    check("led_on_seen", 32'(seen_on), 32'(exp_on));
    check("led_off_seen", 32'(seen_off), 32'(exp_off));
  endtask

  task automatic check_timestamp();
    logic [31:0] rnd;
    logic [31:0] data;
    logic [31:0] prev;
    logic [1:0]  resp;
    time         t0;
    time         elapsed;
    goto_mode(avionics_pkg::IDLE);
    // Keep clear of the counter wrap
    rnd = next_rand();
    send_cmd(avionics_pkg::TIME_LOAD, {9'h0, rnd[22:0]});
    axil_read(`AV_REG_TIME, data, resp);
    check("timestamp_loaded", data, 32'(exp_time));
    // Start taken before the write, an upper bound on run time
    t0 = $time;
    goto_mode(avionics_pkg::RUNNING);
    prev = 32'(exp_time);
    repeat (12) begin
      axil_read(`AV_REG_TIME, data, resp);
      elapsed = ($time - t0) / CLK_PERIOD;
      check("timestamp_not_decreasing", 32'(data >= prev), 32'd1);
      check("timestamp_rate",
            32'((data - 32'(exp_time)) <= (elapsed / `AV_MS_PERIOD + 1)), 32'd1);
      prev = data;
    end
    check("timestamp_advanced", 32'(prev > 32'(exp_time)), 32'd1);
    // Frozen once out of running
    goto_mode(avionics_pkg::SHUTDOWN);
    axil_read(`AV_REG_TIME, prev, resp);
    repeat (3 * `AV_MS_PERIOD) @(posedge clk);
    axil_read(`AV_REG_TIME, data, resp);
    check("timestamp_frozen", data, prev);
    exp_time = prev[`AV_TS_W-1:0];
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    logic [1:0]  resp;
    lcg_state = 32'h2575_6f2b;
    exp_mode  = avionics_pkg::IDLE;
    exp_fault = 1'b0;
    exp_time  = '0;
    arst_n  = 1'b0;
    btn     = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // Reset state
    @(negedge clk);
    check("led", 32'(led), 32'h0);
    check("bvalid", 32'(bvalid), 32'h0);
    check("rvalid", 32'(rvalid), 32'h0);
    check_status();

    // Random mode commands
    repeat (200) begin
      rnd = next_rand();
      if (rnd[0]) begin
        send_cmd(avionics_pkg::ADVANCE, next_rand());
      end else begin
        send_cmd(avionics_pkg::GOTO, next_rand());
      end
      check_status();
    end

    // Reserved op, fault sticky until idle
    goto_mode(avionics_pkg::RUNNING);
    send_cmd(avionics_pkg::RESERVED, next_rand());
    check_status();
    send_cmd(avionics_pkg::ADVANCE, 32'h0);
    check_status();
    send_cmd(avionics_pkg::ADVANCE, 32'h0);
    check_status();
    // Unknown addresses
    axil_write(4'hc, next_rand(), resp);
    check("bresp_bad_addr", 32'(resp), 32'(RESP_SLVERR));
    exp_fault = 1'b1;
    check_status();
    goto_mode(avionics_pkg::IDLE);
    check_status();
    axil_read(4'hc, data, resp);
    check("rresp_bad_addr", 32'(resp), 32'(RESP_SLVERR));
    check("rdata_bad_addr", data, 32'h0);

    // Button, one full lap then a glitch
    repeat (4) press_button();
    glitch_button();

    // LED patterns
    check_leds(avionics_pkg::IDLE, 2 * `AV_SLOW_PERIOD, 1'b0, 1'b1);
    check_leds(avionics_pkg::STARTUP, 2 * `AV_SLOW_PERIOD, 1'b1, 1'b1);
    check_leds(avionics_pkg::RUNNING, 2 * `AV_SLOW_PERIOD, 1'b1, 1'b0);
    check_leds(avionics_pkg::SHUTDOWN, 2 * `AV_FAST_PERIOD, 1'b1, 1'b1);

    // Timestamp load and count
    repeat (3) check_timestamp();

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verilog/avionics_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avionics control core parameters
// Bus widths, register map, debounce and tick periods
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AVIONICS_PARAMS_SVH
`define AVIONICS_PARAMS_SVH

// AXI4-Lite port widths
`define AV_ADDR_W 4
`define AV_DATA_W 32

// Millisecond timestamp width
`define AV_TS_W 24

// Register byte offsets
`define AV_REG_CMD    4'h0
`define AV_REG_STATUS 4'h4
`define AV_REG_TIME   4'h8

// Stable cycles before a button level is accepted
`define AV_DEBOUNCE_CYCLES 16

// Clocks per ms tick, then blink half-periods
`define AV_MS_PERIOD   10
`define AV_SLOW_PERIOD 40
`define AV_FAST_PERIOD 20

`endif

// File: verilog/avionics_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avionics control core types
// Board modes, host command words and status word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "avionics_params.svh"

package avionics_pkg;

  // Board sequencer modes
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    STARTUP  = 2'd1,
    RUNNING  = 2'd2,
    SHUTDOWN = 2'd3
  } board_mode_e;

  // Host command opcodes, top two bits of the command word
  typedef enum logic [1:0] {
    ADVANCE   = 2'd0,
    GOTO      = 2'd1,
    TIME_LOAD = 2'd2,
    RESERVED  = 2'd3
  } cmd_op_e;

  // Command word seen as a mode request
  typedef struct packed {
    cmd_op_e     op;
    logic [27:0] rsvd;
    board_mode_e target;
  } mode_cmd_t;

  // Command word seen as a timestamp load
  typedef struct packed {
    cmd_op_e              op;
    logic [5:0]           rsvd;
    logic [`AV_TS_W-1:0]  value;
  } time_cmd_t;

  // Same 32 bits, two decodes; op lines up in both
  typedef union packed {
    mode_cmd_t mode_cmd;
    time_cmd_t time_cmd;
  } cmd_word_u;

  // Decoded command from register port to sequencer
  typedef struct packed {
    logic                valid;
    cmd_op_e             op;
    board_mode_e         target;
    logic [`AV_TS_W-1:0] value;
  } board_cmd_t;

  // Host-visible status register
  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic        running;
    logic        fault;
    logic [3:0]  rsvd_lo;
    board_mode_e mode;
  } status_t;

endpackage

// File: verilog/avionics_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avionics control core top level
// Button, tick clocks, host port, sequencer, LEDs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "avionics_params.svh"

module avionics_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  btn,
  output logic [7:0]            led,
  // AXI4-Lite slave
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`AV_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [`AV_DATA_W-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [`AV_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [`AV_DATA_W-1:0] rdata,
  output logic [1:0]            rresp
);

  logic                      press;
  logic                      ms_tick;
  logic                      slow_wave;
  logic                      fast_wave;
  avionics_pkg::board_cmd_t  cmd;
  avionics_pkg::board_mode_e mode;
  avionics_pkg::status_t     status;
  logic [`AV_TS_W-1:0]       timestamp;
  logic                      fault;

  // On/off button conditioner
  button_debounce i_debounce (
    .clk    (clk),
    .arst_n (arst_n),
    .btn    (btn),
    .press  (press)
  );

  // Timestamp rate
  tick_gen #(.PERIOD(`AV_MS_PERIOD)) i_ms_tick (
    .clk    (clk),
    .arst_n (arst_n),
    .tick   (ms_tick),
    .wave   ()
  );

  // Startup blink
  tick_gen #(.PERIOD(`AV_SLOW_PERIOD)) i_slow_blink (
    .clk    (clk),
    .arst_n (arst_n),
    .tick   (),
    .wave   (slow_wave)
  );

  // Shutdown blink
  tick_gen #(.PERIOD(`AV_FAST_PERIOD)) i_fast_blink (
    .clk    (clk),
    .arst_n (arst_n),
    .tick   (),
    .wave   (fast_wave)
  );

  host_regs i_host_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .status    (status),
    .timestamp (timestamp),
    .cmd       (cmd)
  );

  board_sequencer i_sequencer (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .press     (press),
    .ms_tick   (ms_tick),
    .mode      (mode),
    .timestamp (timestamp),
    .fault     (fault)
  );

  indicator i_indicator (
    .clk       (clk),
    .arst_n    (arst_n),
    .mode      (mode),
    .fault     (fault),
    .slow_wave (slow_wave),
    .fast_wave (fast_wave),
    .led       (led),
    .status    (status)
  );

endmodule

// File: verilog/board_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board sequencer (execute)
// Mode FSM, fault flag and ms timestamp counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "avionics_params.svh"

module board_sequencer (
  input  logic                        clk,
  input  logic                        arst_n,
  input  avionics_pkg::board_cmd_t    cmd,
  input  logic                        press,
  input  logic                        ms_tick,
  output avionics_pkg::board_mode_e   mode,
  output logic [`AV_TS_W-1:0]         timestamp,
  output logic                        fault
);

  avionics_pkg::board_mode_e mode_nxt;
  logic                      mode_upd;

  // Fixed cycle idle -> startup -> running -> shutdown -> idle
  function automatic avionics_pkg::board_mode_e step_mode(
    input avionics_pkg::board_mode_e m
  );
    avionics_pkg::board_mode_e nxt;
    case (m)
      avionics_pkg::IDLE:    nxt = avionics_pkg::STARTUP;
      avionics_pkg::STARTUP: nxt = avionics_pkg::RUNNING;
      avionics_pkg::RUNNING: nxt = avionics_pkg::SHUTDOWN;
      default:               nxt = avionics_pkg::IDLE;
    endcase
    return nxt;
  endfunction

  // Next mode; a host command beats a press in the same cycle
  always_comb begin
    mode_nxt = mode;
    mode_upd = 1'b0;
    if (cmd.valid) begin
      case (cmd.op)
        avionics_pkg::ADVANCE: begin
          mode_nxt = step_mode(mode);
          mode_upd = 1'b1;
        end
        avionics_pkg::GOTO: begin
          mode_nxt = cmd.target;
          mode_upd = 1'b1;
        end
        default: ;
      endcase
    end else if (press) begin
      mode_nxt = step_mode(mode);
      mode_upd = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode      <= avionics_pkg::IDLE;
      fault     <= 1'b0;
      timestamp <= '0;
    end else begin
      mode <= mode_nxt;
      // Sticky fault, cleared by a move into idle
      if (cmd.valid && cmd.op == avionics_pkg::RESERVED) begin
        fault <= 1'b1;
      end else if (mode_upd && mode_nxt == avionics_pkg::IDLE) begin
        fault <= 1'b0;
      end
      // Load wins over counting
      if (cmd.valid && cmd.op == avionics_pkg::TIME_LOAD) begin
        timestamp <= cmd.value;
      end else if (ms_tick && mode == avionics_pkg::RUNNING) begin
        // Free-running, wraps at full width
        timestamp <= timestamp + 1'b1;
      end
    end
  end

  // Reserved op from the host always leaves a fault behind
  a_reserved_fault : assert property (@(posedge clk) disable iff (!arst_n)
    cmd.valid && cmd.op == avionics_pkg::RESERVED |=> fault);

endmodule

// File: verilog/button_debounce.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button conditioner
// Sync, debounce and one press pulse per press
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "avionics_params.svh"

module button_debounce (
  input  logic clk,
  input  logic arst_n,
  input  logic btn,
  output logic press
);

  localparam int CNT_W = $clog2(`AV_DEBOUNCE_CYCLES + 1);

  // Two-flop synchronizer stages
  logic             sync_q1;
  logic             sync_q2;
  // Accepted (debounced) level
  logic             level;
  logic [CNT_W-1:0] stable_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1    <= 1'b0;
      sync_q2    <= 1'b0;
      level      <= 1'b0;
      stable_cnt <= '0;
      press      <= 1'b0;
    end else begin
      sync_q1 <= btn;
      sync_q2 <= sync_q1;
      press   <= 1'b0;
      // Matches accepted level, restart the window
      if (sync_q2 == level) begin
        stable_cnt <= '0;
      end else if (stable_cnt == CNT_W'(`AV_DEBOUNCE_CYCLES - 1)) begin
        // New level held long enough
        level      <= sync_q2;
        stable_cnt <= '0;
        // Pulse only on the rising edge
        press      <= sync_q2;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

// File: verilog/host_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register port (decode)
// AXI4-Lite slave, command decode, status/time reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "avionics_params.svh"

module host_regs (
  input  logic                        clk,
  input  logic                        arst_n,
  // Write address channel
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AV_ADDR_W-1:0]       awaddr,
  // Write data channel
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [`AV_DATA_W-1:0]       wdata,
  // Write response channel
  output logic                        bvalid,
  input  logic                        bready,
  output logic [1:0]                  bresp,
  // Read address channel
  input  logic                        arvalid,
  output logic                        arready,
  input  logic [`AV_ADDR_W-1:0]       araddr,
  // Read data channel
  output logic                        rvalid,
  input  logic                        rready,
  output logic [`AV_DATA_W-1:0]       rdata,
  output logic [1:0]                  rresp,
  // Core side
  input  avionics_pkg::status_t       status,
  input  logic [`AV_TS_W-1:0]         timestamp,
  output avionics_pkg::board_cmd_t    cmd
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                   wr_accept;
  logic                   rd_accept;
  logic                   wr_addr_ok;
  avionics_pkg::cmd_op_e  wr_op;
  avionics_pkg::cmd_word_u wword;

  // Address and data taken together, one response at a time
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  // No new read while data still waits for rready
  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;

  // Command decode
  assign wword      = wdata;
  assign wr_addr_ok = (awaddr == `AV_REG_CMD);
  // Bad address turns into a reserved op so it still faults
  assign wr_op      = wr_addr_ok ? wword.mode_cmd.op : avionics_pkg::RESERVED;

  always_comb begin
    cmd       = '0;
    cmd.valid = wr_accept;
    cmd.op    = wr_op;
    case (wr_op)
      // Mode view of the word
      avionics_pkg::GOTO:      cmd.target = wword.mode_cmd.target;
      // Time view of the same word
      avionics_pkg::TIME_LOAD: cmd.value  = wword.time_cmd.value;
      default: ;
    endcase
  end

  // Write response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= (wr_op == avionics_pkg::RESERVED) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Read response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Data captured at address accept, held until rready
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rresp <= RESP_OKAY;
      case (araddr)
        `AV_REG_STATUS: rdata <= status;
        `AV_REG_TIME:   rdata <= {{(`AV_DATA_W - `AV_TS_W){1'b0}}, timestamp};
        // Command register is write-only
        `AV_REG_CMD:    rdata <= '0;
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

  // Response held until the host takes it
  a_bvalid_hold : assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid);

endmodule

// File: verilog/indicator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Indicator (result)
// LED pattern per mode and the packed status word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module indicator (
  input  logic                      clk,
  input  logic                      arst_n,
  input  avionics_pkg::board_mode_e mode,
  input  logic                      fault,
  input  logic                      slow_wave,
  input  logic                      fast_wave,
  output logic [7:0]                led,
  output avionics_pkg::status_t     status
);

  // LEDs lag the mode by one clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led <= 8'h00;
    end else begin
      case (mode)
        avionics_pkg::STARTUP:  led <= {8{slow_wave}};
        avionics_pkg::RUNNING:  led <= 8'hff;
        avionics_pkg::SHUTDOWN: led <= {8{fast_wave}};
        default:                led <= 8'h00;
      endcase
    end
  end

  // Status word for host reads
  always_comb begin
    status         = '0;
    status.mode    = mode;
    status.fault   = fault;
    status.running = (mode == avionics_pkg::RUNNING);
  end

endmodule

// File: verilog/tick_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tick generator
// One-cycle tick every PERIOD clocks, plus a blink wave
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tick_gen #(
  parameter int PERIOD = 2
) (
  input  logic clk,
  input  logic arst_n,
  output logic tick,
  output logic wave
);

  // Holds 0 .. PERIOD-1
  localparam int CW = $clog2(PERIOD);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= CW'(PERIOD - 1);
      tick <= 1'b0;
      wave <= 1'b0;
    end else if (cnt == '0) begin
      // Reload, emit tick, flip wave
      cnt  <= CW'(PERIOD - 1);
      tick <= 1'b1;
      wave <= ~wave;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule
